/* verilog/rv32m_pkg.sv */
package rv32m_pkg;

    // M-extension operations, encoded as their funct3 field
    typedef enum logic [2:0] {
        MUL    = 3'b000,
        MULH   = 3'b001,
        MULHSU = 3'b010,
        MULHU  = 3'b011,
        DIV    = 3'b100,
        DIVU   = 3'b101,
        REM    = 3'b110,
        REMU   = 3'b111
    } md_op_e;

    // The top funct3 bit splits divide class (set) from multiply class (clear)
    localparam int MD_DIV_CLASS_BIT = 2;

endpackage

/* verilog/muldiv_cfg_pkg.sv */
package muldiv_cfg_pkg;

    localparam int XLEN = 32;

    // Physical register tag width
    localparam int TAG_BITS = 6;

    localparam int MUL_STAGES = 3;

    // Pipeline slots plus the one writeback slot in the arbiter
    localparam int MUL_CREDITS = MUL_STAGES + 1;

    // The divider holds a single operation at a time
    localparam int DIV_CREDITS = 1;

endpackage

/* verilog/fu_mul.sv */
module fu_mul (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 issue_valid,
    input  rv32m_pkg::md_op_e                    issue_op,
    input  logic [muldiv_cfg_pkg::TAG_BITS-1:0]  issue_tag,
    input  logic [muldiv_cfg_pkg::XLEN-1:0]      rs1_v,
    input  logic [muldiv_cfg_pkg::XLEN-1:0]      rs2_v,
    output logic                                 mul_res_valid,
    output logic [muldiv_cfg_pkg::TAG_BITS-1:0]  mul_res_tag,
    output logic [muldiv_cfg_pkg::XLEN-1:0]      mul_res_data
);

    localparam int W = muldiv_cfg_pkg::XLEN;

    logic                                 accept;
    logic                                 a_sign;
    logic                                 b_sign;

    logic                                 s1_valid;
    rv32m_pkg::md_op_e                    s1_op;
    logic [muldiv_cfg_pkg::TAG_BITS-1:0]  s1_tag;
    logic signed [W:0]                    s1_a;
    logic signed [W:0]                    s1_b;

    logic                                 s2_valid;
    rv32m_pkg::md_op_e                    s2_op;
    logic [muldiv_cfg_pkg::TAG_BITS-1:0]  s2_tag;
    logic signed [2*W+1:0]                s2_prod;

    assign accept = issue_valid && !issue_op[rv32m_pkg::MD_DIV_CLASS_BIT];

    // MULH treats both operands as signed, MULHSU only rs1
    always_comb begin
        a_sign = rs1_v[W-1] && (issue_op == rv32m_pkg::MULH || issue_op == rv32m_pkg::MULHSU);
        b_sign = rs2_v[W-1] && (issue_op == rv32m_pkg::MULH);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid      <= 1'b0;
            s2_valid      <= 1'b0;
            mul_res_valid <= 1'b0;
        end else begin
            s1_valid      <= accept;
            s2_valid      <= s1_valid;
            mul_res_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_op   <= issue_op;
        s1_tag  <= issue_tag;
        s1_a    <= {a_sign, rs1_v};
        s1_b    <= {b_sign, rs2_v};

        s2_op   <= s1_op;
        s2_tag  <= s1_tag;
        s2_prod <= s1_a * s1_b;

        mul_res_tag <= s2_tag;
        if (s2_op == rv32m_pkg::MUL) begin
            mul_res_data <= s2_prod[W-1:0];
        end else begin
            mul_res_data <= s2_prod[2*W-1:W];
        end
    end

endmodule

/* verilog/fu_div_rem.sv */
module fu_div_rem (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 issue_valid,
    input  rv32m_pkg::md_op_e                    issue_op,
    input  logic [muldiv_cfg_pkg::TAG_BITS-1:0]  issue_tag,
    input  logic [muldiv_cfg_pkg::XLEN-1:0]      rs1_v,
    input  logic [muldiv_cfg_pkg::XLEN-1:0]      rs2_v,
    input  logic                                 div_res_taken,
    output logic                                 div_res_valid,
    output logic [muldiv_cfg_pkg::TAG_BITS-1:0]  div_res_tag,
    output logic [muldiv_cfg_pkg::XLEN-1:0]      div_res_data
);

    localparam int W = muldiv_cfg_pkg::XLEN;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } div_state_e;

    div_state_e                           state;
    logic                                 accept;

    logic                                 op_signed;
    logic                                 a_neg;
    logic                                 b_neg;
    logic [W-1:0]                         a_mag;
    logic [W-1:0]                         b_mag;

    rv32m_pkg::md_op_e                    op_q;
    logic [muldiv_cfg_pkg::TAG_BITS-1:0]  tag_q;
    logic [W-1:0]                         dvd_q;
    logic                                 div_zero_q;
    logic                                 ovf_q;
    logic                                 q_neg_q;
    logic                                 r_neg_q;

    logic [W-1:0]                         quo_q;
    logic [W-1:0]                         rem_q;
    logic [W-1:0]                         dsr_q;
    logic [$clog2(W)-1:0]                 cnt_q;

    logic [W:0]                           rem_shift;
    logic [W:0]                           diff;
    logic [W-1:0]                         q_res;
    logic [W-1:0]                         r_res;

    assign accept = issue_valid && issue_op[rv32m_pkg::MD_DIV_CLASS_BIT] && (state == IDLE);

    // Operand magnitudes for the unsigned core
    always_comb begin
        op_signed = (issue_op == rv32m_pkg::DIV) || (issue_op == rv32m_pkg::REM);
        a_neg     = op_signed && rs1_v[W-1];
        b_neg     = op_signed && rs2_v[W-1];
        a_mag     = a_neg ? (W'(0) - rs1_v) : rs1_v;
        b_mag     = b_neg ? (W'(0) - rs2_v) : rs2_v;
    end

    // One restoring step: shift in the next dividend bit and try the subtract
    always_comb begin
        rem_shift = {rem_q, quo_q[W-1]};
        diff      = rem_shift - {1'b0, dsr_q};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (accept) state <= RUN;
                RUN:  if (cnt_q == '1) state <= DONE;
                DONE: if (div_res_taken) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q       <= issue_op;
            tag_q      <= issue_tag;
            dvd_q      <= rs1_v;
            div_zero_q <= (rs2_v == '0);
            ovf_q      <= op_signed && (rs1_v == {1'b1, {(W-1){1'b0}}}) && (rs2_v == '1);
            q_neg_q    <= a_neg ^ b_neg;
            r_neg_q    <= a_neg;
            quo_q      <= a_mag;
            dsr_q      <= b_mag;
            rem_q      <= '0;
            cnt_q      <= '0;
        end else if (state == RUN) begin
            cnt_q <= cnt_q + 1'b1;
            if (!diff[W]) begin
                rem_q <= diff[W-1:0];
                quo_q <= {quo_q[W-2:0], 1'b1};
            end else begin
                rem_q <= rem_shift[W-1:0];
                quo_q <= {quo_q[W-2:0], 1'b0};
            end
        end
    end

    // Sign fix-up, then the divide-by-zero and overflow rules override
    always_comb begin
        q_res = q_neg_q ? (W'(0) - quo_q) : quo_q;
        r_res = r_neg_q ? (W'(0) - rem_q) : rem_q;
        if (div_zero_q) begin
            q_res = '1;
            r_res = dvd_q;
        end else if (ovf_q) begin
            q_res = dvd_q;
            r_res = '0;
        end
    end

    always_comb begin
        case (op_q)
            rv32m_pkg::DIV, rv32m_pkg::DIVU: div_res_data = q_res;
            default: div_res_data = r_res;
        endcase
    end

    assign div_res_valid = (state == DONE);
    assign div_res_tag   = tag_q;

endmodule

/* verilog/muldiv_result_arbiter.sv */
module muldiv_result_arbiter (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 mul_res_valid,
    input  logic [muldiv_cfg_pkg::TAG_BITS-1:0]  mul_res_tag,
    input  logic [muldiv_cfg_pkg::XLEN-1:0]      mul_res_data,
    input  logic                                 div_res_valid,
    input  logic [muldiv_cfg_pkg::TAG_BITS-1:0]  div_res_tag,
    input  logic [muldiv_cfg_pkg::XLEN-1:0]      div_res_data,
    output logic                                 div_res_taken,
    output logic                                 wb_valid,
    output logic [muldiv_cfg_pkg::TAG_BITS-1:0]  wb_tag,
    output logic [muldiv_cfg_pkg::XLEN-1:0]      rd_v,
    output logic                                 mul_credit,
    output logic                                 div_credit
);

    logic sel_mul;
    logic sel_div;

    // The multiplier cannot stall, so it always wins and the divider waits
    assign sel_mul       = mul_res_valid;
    assign sel_div       = div_res_valid && !mul_res_valid;
    assign div_res_taken = sel_div;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid   <= 1'b0;
            mul_credit <= 1'b0;
            div_credit <= 1'b0;
        end else begin
            wb_valid   <= sel_mul || sel_div;
            mul_credit <= sel_mul;
            div_credit <= sel_div;
        end
    end

    always_ff @(posedge clk) begin
        if (sel_mul) begin
            wb_tag <= mul_res_tag;
            rd_v   <= mul_res_data;
        end else begin
            wb_tag <= div_res_tag;
            rd_v   <= div_res_data;
        end
    end

endmodule

/* verilog/muldiv_unit.sv */
module muldiv_unit (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 issue_valid,
    input  rv32m_pkg::md_op_e                    issue_op,
    input  logic [muldiv_cfg_pkg::TAG_BITS-1:0]  issue_tag,
    input  logic [muldiv_cfg_pkg::XLEN-1:0]      rs1_v,
    input  logic [muldiv_cfg_pkg::XLEN-1:0]      rs2_v,
    output logic                                 mul_credit,
    output logic                                 div_credit,
    output logic                                 wb_valid,
    output logic [muldiv_cfg_pkg::TAG_BITS-1:0]  wb_tag,
    output logic [muldiv_cfg_pkg::XLEN-1:0]      rd_v
);

    logic                                 mul_res_valid;
    logic [muldiv_cfg_pkg::TAG_BITS-1:0]  mul_res_tag;
    logic [muldiv_cfg_pkg::XLEN-1:0]      mul_res_data;

    logic                                 div_res_valid;
    logic [muldiv_cfg_pkg::TAG_BITS-1:0]  div_res_tag;
    logic [muldiv_cfg_pkg::XLEN-1:0]      div_res_data;
    logic                                 div_res_taken;

    // Both units see every issue and pick out their own class
    fu_mul fu_mul_inst (
        .clk           (clk),
        .rst           (rst),
        .issue_valid   (issue_valid),
        .issue_op      (issue_op),
        .issue_tag     (issue_tag),
        .rs1_v         (rs1_v),
        .rs2_v         (rs2_v),
        .mul_res_valid (mul_res_valid),
        .mul_res_tag   (mul_res_tag),
        .mul_res_data  (mul_res_data)
    );

    fu_div_rem fu_div_rem_inst (
        .clk           (clk),
        .rst           (rst),
        .issue_valid   (issue_valid),
        .issue_op      (issue_op),
        .issue_tag     (issue_tag),
        .rs1_v         (rs1_v),
        .rs2_v         (rs2_v),
        .div_res_taken (div_res_taken),
        .div_res_valid (div_res_valid),
        .div_res_tag   (div_res_tag),
        .div_res_data  (div_res_data)
    );

    muldiv_result_arbiter muldiv_result_arbiter_inst (
        .clk           (clk),
        .rst           (rst),
        .mul_res_valid (mul_res_valid),
        .mul_res_tag   (mul_res_tag),
        .mul_res_data  (mul_res_data),
        .div_res_valid (div_res_valid),
        .div_res_tag   (div_res_tag),
        .div_res_data  (div_res_data),
        .div_res_taken (div_res_taken),
        .wb_valid      (wb_valid),
        .wb_tag        (wb_tag),
        .rd_v          (rd_v),
        .mul_credit    (mul_credit),
        .div_credit    (div_credit)
    );

endmodule

/* verification/tb_muldiv_ref.svh */
`ifndef TB_MULDIV_REF_SVH
`define TB_MULDIV_REF_SVH

// Expected result of one M-extension operation, taken from the ISA rules
function automatic logic [muldiv_cfg_pkg::XLEN-1:0] ref_result(
    input rv32m_pkg::md_op_e               op,
    input logic [muldiv_cfg_pkg::XLEN-1:0] a,
    input logic [muldiv_cfg_pkg::XLEN-1:0] b
);
    logic signed [2*muldiv_cfg_pkg::XLEN-1:0] sa;
    logic signed [2*muldiv_cfg_pkg::XLEN-1:0] sb;
    logic signed [2*muldiv_cfg_pkg::XLEN-1:0] ua;
    logic signed [2*muldiv_cfg_pkg::XLEN-1:0] ub;
    logic signed [2*muldiv_cfg_pkg::XLEN-1:0] prod;
    logic signed [2*muldiv_cfg_pkg::XLEN-1:0] sdiv;
    logic                                     div_zero;
    logic                                     ovf;

    sa       = {{muldiv_cfg_pkg::XLEN{a[muldiv_cfg_pkg::XLEN-1]}}, a};
    sb       = {{muldiv_cfg_pkg::XLEN{b[muldiv_cfg_pkg::XLEN-1]}}, b};
    ua       = {{muldiv_cfg_pkg::XLEN{1'b0}}, a};
    ub       = {{muldiv_cfg_pkg::XLEN{1'b0}}, b};
    div_zero = (b == '0);
    ovf      = (a == {1'b1, {(muldiv_cfg_pkg::XLEN-1){1'b0}}}) && (b == '1);
    prod     = ua * ub;

    case (op)
        rv32m_pkg::MUL:    return prod[muldiv_cfg_pkg::XLEN-1:0];
        rv32m_pkg::MULH:   prod = sa * sb;
        rv32m_pkg::MULHSU: prod = sa * ub;
        rv32m_pkg::MULHU:  prod = ua * ub;
        // Divide by zero and signed overflow have fixed answers in RISC-V
        rv32m_pkg::DIV: begin
            if (div_zero) return '1;
            if (ovf) return a;
            sdiv = sa / sb;
            return sdiv[muldiv_cfg_pkg::XLEN-1:0];
        end
        rv32m_pkg::DIVU:   return div_zero ? '1 : a / b;
        rv32m_pkg::REM: begin
            if (div_zero) return a;
            if (ovf) return '0;
            sdiv = sa % sb;
            return sdiv[muldiv_cfg_pkg::XLEN-1:0];
        end
        rv32m_pkg::REMU:   return div_zero ? a : a % b;
        default:           return 'x;
    endcase
    return prod[2*muldiv_cfg_pkg::XLEN-1:muldiv_cfg_pkg::XLEN];
endfunction

`endif

/* verification/tb_muldiv_unit.sv */
module tb_muldiv_unit;

    localparam int NTAGS = 2 ** muldiv_cfg_pkg::TAG_BITS;

    logic                                 clk;
    logic                                 rst;
    logic                                 issue_valid;
    rv32m_pkg::md_op_e                    issue_op;
    logic [muldiv_cfg_pkg::TAG_BITS-1:0]  issue_tag;
    logic [muldiv_cfg_pkg::XLEN-1:0]      rs1_v;
    logic [muldiv_cfg_pkg::XLEN-1:0]      rs2_v;
    logic                                 mul_credit;
    logic                                 div_credit;
    logic                                 wb_valid;
    logic [muldiv_cfg_pkg::TAG_BITS-1:0]  wb_tag;
    logic [muldiv_cfg_pkg::XLEN-1:0]      rd_v;

    integer seed = 32'h3cec21f3;
    int     cyc = 0;
    int     mul_issued = 0;
    int     mul_returned = 0;
    int     div_issued = 0;
    int     div_returned = 0;
    int     issued_total = 0;
    int     retired_total = 0;
    logic [muldiv_cfg_pkg::TAG_BITS-1:0] next_tag = '0;

    // Scoreboard indexed by tag; a tag is pending while issued_n and retired_n differ
    int                              issued_n [NTAGS];
    int                              retired_n [NTAGS];
    int                              iss_cyc [NTAGS];
    bit                              is_div [NTAGS];
    logic [muldiv_cfg_pkg::XLEN-1:0] exp_val [NTAGS];

    logic [muldiv_cfg_pkg::XLEN-1:0] corner_a [7] = '{32'h8000_0000, 32'h8000_0000,
        32'h7fff_ffff, 32'hffff_ffff, 32'h1234_5678, 32'hffff_fff9, 32'h0000_0007};
    logic [muldiv_cfg_pkg::XLEN-1:0] corner_b [7] = '{32'h8000_0000, 32'hffff_ffff,
        32'h8000_0000, 32'hffff_ffff, 32'h0000_0000, 32'h0000_0002, 32'hffff_fffe};

    `include "tb_muldiv_ref.svh"

    muldiv_unit muldiv_unit_inst (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_tag   (issue_tag),
        .rs1_v       (rs1_v),
        .rs2_v       (rs2_v),
        .mul_credit  (mul_credit),
        .div_credit  (div_credit),
        .wb_valid    (wb_valid),
        .wb_tag      (wb_tag),
        .rd_v        (rd_v)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (mul_credit) mul_returned <= mul_returned + 1;
        if (div_credit) div_returned <= div_returned + 1;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    function automatic int credits_left(input bit div_class);
        if (div_class) return muldiv_cfg_pkg::DIV_CREDITS - div_issued + div_returned;
        return muldiv_cfg_pkg::MUL_CREDITS - mul_issued + mul_returned;
    endfunction

    // Issues one operation on a rising edge once a credit and a free tag exist
    task automatic send(input rv32m_pkg::md_op_e op, input logic [31:0] a,
                        input logic [31:0] b);
        bit                                  div_class;
        int                                  waited;
        logic [muldiv_cfg_pkg::TAG_BITS-1:0] t;
        div_class = op[rv32m_pkg::MD_DIV_CLASS_BIT];
        waited = 0;
        while (credits_left(div_class) == 0) begin
            issue_valid <= 1'b0;
            @(posedge clk);
            waited++;
            if (waited > 200) report_failure("timed out waiting for a free credit");
        end
        t = next_tag;
        waited = 0;
        while (issued_n[t] != retired_n[t]) begin
            t = t + 1'b1;
            waited++;
            if (waited > NTAGS) report_failure("no free tag left to issue with");
        end
        next_tag     = t + 1'b1;
        exp_val[t]   = ref_result(op, a, b);
        is_div[t]    = div_class;
        iss_cyc[t]   = cyc + 1;
        issued_n[t]  = issued_n[t] + 1;
        issued_total = issued_total + 1;
        if (div_class) div_issued = div_issued + 1;
        else mul_issued = mul_issued + 1;
        issue_valid <= 1'b1;
        issue_op    <= op;
        issue_tag   <= t;
        rs1_v       <= a;
        rs2_v       <= b;
        @(posedge clk);
    endtask

    always @(negedge clk) begin
        if (!rst && wb_valid) begin
            assert (issued_n[wb_tag] == retired_n[wb_tag] + 1) else
                report_failure($sformatf("writeback of tag %0d that is not pending", wb_tag));
            assert (rd_v === exp_val[wb_tag]) else
                report_failure($sformatf("mismatch at %0t: tag %0d gave %h, expected %h",
                                         $time, wb_tag, rd_v, exp_val[wb_tag]));
            assert (mul_credit == !is_div[wb_tag] && div_credit == is_div[wb_tag]) else
                report_failure("credit pulse does not match the class of the writeback");
            if (!is_div[wb_tag]) begin
                assert (cyc - iss_cyc[wb_tag] == 4) else
                    report_failure($sformatf("mismatch at %0t: multiply latency %0d, expected 4",
                                             $time, cyc - iss_cyc[wb_tag]));
            end
            retired_n[wb_tag] = retired_n[wb_tag] + 1;
            retired_total     = retired_total + 1;
        end else if (!rst) begin
            assert (!mul_credit && !div_credit) else
                report_failure("credit pulse without a writeback");
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        int          k;
        int          n;
        int          waited;
        clk         = 1'b0;
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue_op    = rv32m_pkg::MUL;
        issue_tag   = '0;
        rs1_v       = '0;
        rs2_v       = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // Signed extremes, divide by zero and overflow across all eight operations
        for (k = 0; k < 8; k++) begin
            for (n = 0; n < 7; n++) send(rv32m_pkg::md_op_e'(3'(k)), corner_a[n], corner_b[n]);
        end

        // Multiply bursts while a divide is still iterating
        for (k = 0; k < 3; k++) begin
            send(rv32m_pkg::DIV, $random(seed), $random(seed));
            for (n = 0; n < 12; n++) begin
                r = $random(seed);
                send(rv32m_pkg::md_op_e'({1'b0, r[1:0]}), $random(seed), $random(seed));
            end
        end

        for (k = 0; k < 300; k++) begin
            r = $random(seed);
            a = $random(seed);
            b = (r[7:4] == 4'h0) ? '0 : $random(seed);
            send(rv32m_pkg::md_op_e'(r[2:0]), a, b);
        end
        issue_valid <= 1'b0;

        waited = 0;
        while (retired_total != issued_total) begin
            @(posedge clk);
            waited++;
            if (waited > 500) report_failure("timed out waiting for operations to drain");
        end
        repeat (20) @(posedge clk);
        assert (credits_left(1'b0) == muldiv_cfg_pkg::MUL_CREDITS &&
                credits_left(1'b1) == muldiv_cfg_pkg::DIV_CREDITS) else
            report_failure("credit counts did not return to their reset values");
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* all.f */
+incdir+verification
verilog/rv32m_pkg.sv
verilog/muldiv_cfg_pkg.sv
verilog/fu_mul.sv
verilog/fu_div_rem.sv
verilog/muldiv_result_arbiter.sv
verilog/muldiv_unit.sv
verification/tb_muldiv_unit.sv

/* Makefile */
# Verilator flow for the M-extension execution cluster
# Override any of these on the command line, e.g. make sim LOG=run1.log

VERILATOR ?= verilator
TOP       ?= tb_muldiv_unit
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# The binary stops early on a failed check, so pass is read from the log
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
